// ==== adc_trigger.f ====
rtl/adc_trig_pkg.sv
rtl/adc_frontend.sv
rtl/trig_channel.sv
rtl/trig_combiner.sv
rtl/trig_regs.sv
rtl/adc_trigger_top.sv
tests/adc_trigger_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the trigger testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module adc_trigger_tb \
    -f adc_trigger.f -o adc_trigger_sim

out=$(./obj_dir/adc_trigger_sim)
echo "$out"

if echo "$out" | grep -q "TESTBENCH PASSED"; then
    exit 0
else
    exit 1
fi

// ==== tests/adc_trigger_tb.sv ====
module adc_trigger_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_CH = 4;
    localparam int SAMPLE_W = 16;
    localparam int WORD_W = 2 * SAMPLE_W;

    logic                         adc_clk;
    logic                         rst_n;
    logic [NUM_CH*WORD_W-1:0]     adc_data;
    logic [NUM_CH-1:0]            adc_valid;
    logic                         wb_cyc;
    logic                         wb_stb;
    logic                         wb_we;
    logic [3:0]                   wb_adr;
    logic [31:0]                  wb_wdata;
    logic [31:0]                  wb_rdata;
    logic                         wb_ack;
    logic                         trigger_out;

    integer seed = 32'h8453b8f2;
    int     err_cnt;
    int     pass_cnt;
    int     fail_cnt;
    int     check_cnt;

    // Shadow of the configuration as last written
    int                sh_level [NUM_CH];
    logic [NUM_CH-1:0] sh_below;
    logic [NUM_CH-1:0] sh_enable;
    logic              sh_mode;
    // High while a configuration write is in flight
    logic              busy;

    // Model state, last pair sum per channel and a 4 deep result pipeline
    int                m_sum [NUM_CH];
    int                stable;
    logic [3:0]        pipe_trig;
    logic [NUM_CH-1:0] pipe_hits [4];
    logic              prev_exp;
    logic              count_restart;
    int                m_count;
    logic [NUM_CH-1:0] m_status;

    adc_trigger_top #(
        .NUM_CH   (NUM_CH),
        .SAMPLE_W (SAMPLE_W)
    ) dut_i (
        .adc_clk     (adc_clk),
        .rst_n       (rst_n),
        .adc_data    (adc_data),
        .adc_valid   (adc_valid),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_wdata    (wb_wdata),
        .wb_rdata    (wb_rdata),
        .wb_ack      (wb_ack),
        .trigger_out (trigger_out)
    );

    // 100 ns clock
    always #50 adc_clk = ~adc_clk;

    //////////////////////////////
    // Reference model
    //////////////////////////////

    // Two sign extended samples added, first sample in the low half
    function automatic int word_sum(input logic [WORD_W-1:0] word);
        return int'($signed(word[SAMPLE_W-1:0])) + int'($signed(word[WORD_W-1:SAMPLE_W]));
    endfunction

    // Expected trigger from the held sums, levels and polarity
    function automatic logic ref_trigger(input logic [NUM_CH-1:0] mask, input logic and_m,
                                         output logic [NUM_CH-1:0] hit_bits);
        logic [NUM_CH-1:0] raw;
        logic              fire;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            // Strict compare, equal never fires
            raw[ch] = sh_below[ch] ? (m_sum[ch] < sh_level[ch]) : (m_sum[ch] > sh_level[ch]);
        end
        hit_bits = raw & mask;
        if (and_m) begin
            fire = (hit_bits == mask) && (mask != '0);
        end else begin
            fire = (hit_bits != '0);
        end
        return fire;
    endfunction

    // Model step on the same edge where the DUT samples its inputs
    always @(posedge adc_clk) begin
        logic [NUM_CH-1:0] hits;
        logic              exp_trig;
        // Stable counts edges since the last configuration write
        if (!rst_n || busy) begin
            stable = 0;
        end else if (stable < 4) begin
            stable = stable + 1;
        end
        for (int ch = 0; ch < NUM_CH; ch++) begin
            if (!rst_n) begin
                m_sum[ch] = 0;
            end else if (adc_valid[ch]) begin
                m_sum[ch] = word_sum(adc_data[ch*WORD_W +: WORD_W]);
            end
        end
        exp_trig = ref_trigger(sh_enable, sh_mode, hits);
        for (int i = 3; i > 0; i--) begin
            pipe_trig[i] = pipe_trig[i-1];
            pipe_hits[i] = pipe_hits[i-1];
        end
        pipe_trig[0] = exp_trig;
        pipe_hits[0] = hits;
        // Rising edges of the expected trigger, first one sets the status
        if (count_restart) begin
            m_count = 0;
            m_status = '0;
            prev_exp = pipe_trig[3];
        end else if (stable >= 4) begin
            if (pipe_trig[3] && !prev_exp) begin
                m_count = m_count + 1;
                if (m_status == '0) begin
                    m_status = pipe_hits[3];
                end
            end
            prev_exp = pipe_trig[3];
        end
    end

    // Compare every cycle once the pipeline holds only current configuration
    always @(negedge adc_clk) begin
        if (stable >= 4) begin
            check_cnt = check_cnt + 1;
            if (trigger_out !== pipe_trig[3]) begin
                $display("Error: trigger_out is %h, expected %h at %0t",
                         trigger_out, pipe_trig[3], $time);
                err_cnt = err_cnt + 1;
            end
        end
    end

    //////////////////////////////
    // Bus and stimulus tasks
    //////////////////////////////

    // One Wishbone classic cycle, entered and left on a falling edge
    task automatic wb_access(input logic we, input logic [3:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        waited = 0;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_wdata = wdata;
        @(negedge adc_clk);
        while (!wb_ack && waited < 20) begin
            @(negedge adc_clk);
            waited++;
        end
        if (!wb_ack) begin
            // No answer from the slave, end the cycle
            $display("No Wishbone ack within 20 cycles at address %0h", adr);
            err_cnt++;
            rdata = 'x;
        end else begin
            rdata = wb_rdata;
            // Hold through the ack edge so a write lands
            @(negedge adc_clk);
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic write_level(input int ch, input int lvl);
        adc_trig_pkg::reg_word_u w;
        logic [31:0]             unused_rd;
        w = '0;
        w.lvl.level = 18'(lvl);
        busy = 1'b1;
        wb_access(1'b1, 4'(int'(adc_trig_pkg::reg_level_base) + ch), w, unused_rd);
        sh_level[ch] = lvl;
        busy = 1'b0;
    endtask

    task automatic write_ctrl(input logic clr, input logic mode,
                              input logic [NUM_CH-1:0] bl, input logic [NUM_CH-1:0] en);
        adc_trig_pkg::reg_word_u w;
        logic [31:0]             unused_rd;
        w = '0;
        w.ctrl.clear = clr;
        w.ctrl.and_mode = mode;
        w.ctrl.below[NUM_CH-1:0] = bl;
        w.ctrl.enable[NUM_CH-1:0] = en;
        busy = 1'b1;
        wb_access(1'b1, adc_trig_pkg::reg_ctrl, w, unused_rd);
        sh_below = bl;
        sh_enable = en;
        sh_mode = mode;
        busy = 1'b0;
    endtask

    task automatic expect_word(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s is %h, expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    // Strobe the prepared words, trigger_out answers 4 edges later
    task automatic strobe_and_check(input logic [NUM_CH-1:0] valid, input logic exp);
        adc_valid = valid;
        @(negedge adc_clk);
        adc_valid = '0;
        repeat (3) @(negedge adc_clk);
        if (trigger_out !== exp) begin
            $display("Error: trigger_out is %h, expected %h after word %h",
                     trigger_out, exp, adc_data);
            err_cnt++;
        end
    endtask

    // Random words under random strobes
    task automatic random_run(input int cycles);
        logic [31:0] rnd;
        repeat (cycles) begin
            for (int ch = 0; ch < NUM_CH; ch++) begin
                adc_data[ch*WORD_W +: WORD_W] = $random(seed);
            end
            rnd = $random(seed);
            adc_valid = rnd[NUM_CH-1:0];
            @(negedge adc_clk);
        end
        adc_valid = '0;
    endtask

    task automatic report_test(input string name, input int start_err);
        if (err_cnt == start_err) begin
            pass_cnt++;
            $display("Test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("Test %s: %0d errors", name, err_cnt - start_err);
        end
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        adc_trig_pkg::reg_word_u w;
        logic [31:0]             rd;
        logic [31:0]             rnd;
        logic [31:0]             count0;
        int                      start_err;
        int                      first_chk;
        int                      lv;
        adc_clk = 1'b0;
        rst_n = 1'b0;
        adc_data = '0;
        adc_valid = '0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_wdata = '0;
        busy = 1'b1;
        count_restart = 1'b0;
        sh_below = '0;
        sh_enable = '0;
        sh_mode = 1'b0;
        pipe_trig = '0;
        prev_exp = 1'b0;
        repeat (10) @(negedge adc_clk);
        rst_n = 1'b1;
        busy = 1'b0;

        // Register access
        start_err = err_cnt;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            write_level(ch, $random(seed) % 100000);
        end
        for (int ch = 0; ch < NUM_CH; ch++) begin
            w = '0;
            w.lvl.level = 18'(sh_level[ch]);
            wb_access(1'b0, 4'(int'(adc_trig_pkg::reg_level_base) + ch), '0, rd);
            expect_word($sformatf("wb_rdata level %0d", ch), rd, w);
        end
        write_ctrl(1'b1, 1'b1, 4'b1010, 4'b0110);
        // Clear bit is not stored
        w = '0;
        w.ctrl.and_mode = 1'b1;
        w.ctrl.below[NUM_CH-1:0] = 4'b1010;
        w.ctrl.enable[NUM_CH-1:0] = 4'b0110;
        wb_access(1'b0, adc_trig_pkg::reg_ctrl, '0, rd);
        expect_word("wb_rdata ctrl", rd, w);
        wb_access(1'b0, 4'd5, '0, rd);
        expect_word("wb_rdata unmapped 5", rd, '0);
        wb_access(1'b0, 4'd14, '0, rd);
        expect_word("wb_rdata unmapped 14", rd, '0);
        repeat (5) @(negedge adc_clk);
        wb_access(1'b0, adc_trig_pkg::reg_count, '0, count0);
        wb_access(1'b1, adc_trig_pkg::reg_count, 32'hdead_beef, rd);
        wb_access(1'b0, adc_trig_pkg::reg_count, '0, rd);
        expect_word("wb_rdata count after write", rd, count0);
        report_test("register access", start_err);

        // Single channel, above polarity, sums around the level
        start_err = err_cnt;
        for (int k = 0; k < 2; k++) begin
            lv = (k == 0) ? 1000 : -777;
            write_level(0, lv);
            write_ctrl(1'b0, 1'b0, 4'b0000, 4'b0001);
            for (int d = -1; d <= 1; d++) begin
                adc_data[WORD_W-1:0] = {16'(lv + 3000 + d), 16'(-3000)};
                strobe_and_check(4'b0001, d > 0);
            end
        end
        report_test("single channel", start_err);

        // Channel 1 below a negative level, loud disabled neighbours
        start_err = err_cnt;
        write_level(1, -2000);
        write_ctrl(1'b0, 1'b0, 4'b0010, 4'b0010);
        for (int d = -1; d <= 1; d++) begin
            adc_data = {4{16'(30000), 16'(30000)}};
            adc_data[WORD_W +: WORD_W] = {16'(-1000 + d), 16'(-1000)};
            strobe_and_check(4'b0111, d < 0);
        end
        report_test("polarity", start_err);

        // Random masks and modes, first two with an empty mask
        start_err = err_cnt;
        first_chk = check_cnt;
        for (int it = 0; it < 8; it++) begin
            for (int ch = 0; ch < NUM_CH; ch++) begin
                write_level(ch, $random(seed) % 40000);
            end
            rnd = $random(seed);
            if (it < 2) begin
                write_ctrl(1'b0, it == 1, rnd[7:4], 4'b0000);
            end else begin
                write_ctrl(1'b0, rnd[8], rnd[7:4], rnd[3:0]);
            end
            random_run(40);
        end
        repeat (5) @(negedge adc_clk);
        if (check_cnt == first_chk) begin
            $display("No trigger compares were made during the random run");
            err_cnt++;
        end
        report_test("combining", start_err);

        // Status and event count against the model
        start_err = err_cnt;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            write_level(ch, 20000);
        end
        write_ctrl(1'b0, 1'b0, 4'b0000, 4'b1010);
        repeat (6) @(negedge adc_clk);
        write_ctrl(1'b1, 1'b0, 4'b0000, 4'b1010);
        repeat (6) @(negedge adc_clk);
        count_restart = 1'b1;
        @(negedge adc_clk);
        count_restart = 1'b0;
        random_run(80);
        repeat (6) @(negedge adc_clk);
        wb_access(1'b0, adc_trig_pkg::reg_status, '0, rd);
        expect_word("wb_rdata status", rd, 32'(m_status));
        wb_access(1'b0, adc_trig_pkg::reg_count, '0, rd);
        expect_word("wb_rdata count", rd, 32'(m_count));
        write_ctrl(1'b1, 1'b0, 4'b0000, 4'b1010);
        // Clear pulse reaches the combiner one cycle after the write
        @(negedge adc_clk);
        wb_access(1'b0, adc_trig_pkg::reg_status, '0, rd);
        expect_word("wb_rdata status after clear", rd, '0);
        wb_access(1'b0, adc_trig_pkg::reg_count, '0, rd);
        expect_word("wb_rdata count after clear", rd, '0);
        report_test("status and count", start_err);

        $display("Tests passed %0d, failed %0d, trigger compares %0d",
                 pass_cnt, fail_cnt, check_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== rtl/adc_trigger_top.sv ====
module adc_trigger_top #(
    parameter int NUM_CH = 4,
    parameter int SAMPLE_W = 16
) (
    input  logic                                adc_clk,
    input  logic                                rst_n,
    // ADC stream, channel 0 in the lowest bits
    input  logic [NUM_CH*2*SAMPLE_W-1:0]        adc_data,
    input  logic [NUM_CH-1:0]                   adc_valid,
    // Wishbone classic slave port
    input  logic                                wb_cyc,
    input  logic                                wb_stb,
    input  logic                                wb_we,
    input  logic [adc_trig_pkg::wb_adr_w-1:0]   wb_adr,
    input  logic [adc_trig_pkg::wb_data_w-1:0]  wb_wdata,
    output logic [adc_trig_pkg::wb_data_w-1:0]  wb_rdata,
    output logic                                wb_ack,
    output logic                                trigger_out
);

    // Width of the pair sum and the level seen by a slice
    localparam int LEVEL_W = adc_trig_pkg::level_width(SAMPLE_W);

    // Frontend to slices
    logic [NUM_CH*SAMPLE_W-1:0] sample_first;
    logic [NUM_CH*SAMPLE_W-1:0] sample_second;
    logic [NUM_CH-1:0]          sample_valid;

    // Registers to slices and combiner
    logic [NUM_CH*adc_trig_pkg::level_w-1:0] level;
    logic [NUM_CH-1:0]                       below;
    logic [NUM_CH-1:0]                       enable_mask;
    logic                                    and_mode;
    logic                                    clear;

    // Slices to combiner, combiner back to registers
    logic [NUM_CH-1:0]                       chan_trig;
    logic [NUM_CH-1:0]                       status_mask;
    logic [adc_trig_pkg::wb_data_w-1:0]      event_count;

    //////////////////////////////
    // Datapath
    //////////////////////////////

    adc_frontend #(
        .NUM_CH   (NUM_CH),
        .SAMPLE_W (SAMPLE_W)
    ) u_frontend (
        .adc_clk       (adc_clk),
        .rst_n         (rst_n),
        .adc_data      (adc_data),
        .adc_valid     (adc_valid),
        .sample_first  (sample_first),
        .sample_second (sample_second),
        .sample_valid  (sample_valid)
    );

    // One identical slice per channel
    for (genvar i = 0; i < NUM_CH; i++) begin : g_chan
        trig_channel #(
            .SAMPLE_W (SAMPLE_W)
        ) u_chan (
            .adc_clk       (adc_clk),
            .rst_n         (rst_n),
            .sample_first  (sample_first[i*SAMPLE_W +: SAMPLE_W]),
            .sample_second (sample_second[i*SAMPLE_W +: SAMPLE_W]),
            .sample_valid  (sample_valid[i]),
            .level         (level[i*adc_trig_pkg::level_w +: LEVEL_W]),
            .below         (below[i]),
            .chan_trig     (chan_trig[i])
        );
    end

    trig_combiner #(
        .NUM_CH (NUM_CH)
    ) u_combiner (
        .adc_clk     (adc_clk),
        .rst_n       (rst_n),
        .chan_trig   (chan_trig),
        .enable_mask (enable_mask),
        .and_mode    (and_mode),
        .clear       (clear),
        .trigger_out (trigger_out),
        .status_mask (status_mask),
        .event_count (event_count)
    );

    //////////////////////////////
    // Control registers
    //////////////////////////////

    trig_regs #(
        .NUM_CH (NUM_CH)
    ) u_regs (
        .adc_clk     (adc_clk),
        .rst_n       (rst_n),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_wdata    (wb_wdata),
        .wb_rdata    (wb_rdata),
        .wb_ack      (wb_ack),
        .level       (level),
        .below       (below),
        .enable_mask (enable_mask),
        .and_mode    (and_mode),
        .clear       (clear),
        .status_mask (status_mask),
        .event_count (event_count)
    );

endmodule

// ==== rtl/trig_regs.sv ====
module trig_regs #(
    parameter int NUM_CH = 4
) (
    input  logic                                  adc_clk,
    input  logic                                  rst_n,
    // Wishbone classic slave
    input  logic                                  wb_cyc,
    input  logic                                  wb_stb,
    input  logic                                  wb_we,
    input  logic [adc_trig_pkg::wb_adr_w-1:0]     wb_adr,
    input  logic [adc_trig_pkg::wb_data_w-1:0]    wb_wdata,
    output logic [adc_trig_pkg::wb_data_w-1:0]    wb_rdata,
    output logic                                  wb_ack,
    // Flat levels, channel 0 in the lowest bits
    output logic [NUM_CH*adc_trig_pkg::level_w-1:0] level,
    output logic [NUM_CH-1:0]                     below,
    output logic [NUM_CH-1:0]                     enable_mask,
    output logic                                  and_mode,
    output logic                                  clear,
    // Read back from the combiner
    input  logic [NUM_CH-1:0]                     status_mask,
    input  logic [adc_trig_pkg::wb_data_w-1:0]    event_count
);

    adc_trig_pkg::reg_word_u wr_word;
    adc_trig_pkg::reg_word_u rd_word;

    logic                                    req;
    logic                                    wr_en;
    logic [NUM_CH-1:0]                       lvl_sel;
    logic signed [adc_trig_pkg::level_w-1:0] level_q [NUM_CH];

    //////////////////////////////
    // Bus handshake
    //////////////////////////////

    // New request, not yet acknowledged
    assign req = wb_cyc && wb_stb && !wb_ack;

    // Write lands at the end of the ack cycle
    assign wr_en = wb_cyc && wb_stb && wb_we && wb_ack;

    // Ack for exactly one cycle per request
    always_ff @(posedge adc_clk) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req;
        end
    end

    // Read data presented together with ack
    always_ff @(posedge adc_clk) begin
        if (req) begin
            wb_rdata <= rd_word;
        end
    end

    //////////////////////////////
    // Address decode
    //////////////////////////////

    // One select per level word
    always_comb begin
        for (int i = 0; i < NUM_CH; i++) begin
            lvl_sel[i] = (int'(wb_adr) == int'(adc_trig_pkg::reg_level_base) + i);
        end
    end

    // Write word seen through both views
    assign wr_word = wb_wdata;

    //////////////////////////////
    // Register writes
    //////////////////////////////

    always_ff @(posedge adc_clk) begin
        if (!rst_n) begin
            and_mode <= 1'b0;
            below <= '0;
            enable_mask <= '0;
            clear <= 1'b0;
            for (int i = 0; i < NUM_CH; i++) begin
                level_q[i] <= '0;
            end
        end else begin
            // Clear is a single cycle pulse
            clear <= 1'b0;
            if (wr_en) begin
                // Control view, fields above NUM_CH are dropped
                if (wb_adr == adc_trig_pkg::reg_ctrl) begin
                    clear <= wr_word.ctrl.clear;
                    and_mode <= wr_word.ctrl.and_mode;
                    below <= wr_word.ctrl.below[NUM_CH-1:0];
                    enable_mask <= wr_word.ctrl.enable[NUM_CH-1:0];
                end
                // Level view
                for (int i = 0; i < NUM_CH; i++) begin
                    if (lvl_sel[i]) begin
                        level_q[i] <= wr_word.lvl.level;
                    end
                end
                // Status and count are read only
            end
        end
    end

    //////////////////////////////
    // Read mux
    //////////////////////////////

    always_comb begin
        // Unmapped addresses read as zero
        rd_word = '0;
        if (wb_adr == adc_trig_pkg::reg_ctrl) begin
            // Clear bit always reads as zero
            rd_word.ctrl.and_mode = and_mode;
            rd_word.ctrl.below[NUM_CH-1:0] = below;
            rd_word.ctrl.enable[NUM_CH-1:0] = enable_mask;
        end else if (wb_adr == adc_trig_pkg::reg_status) begin
            rd_word[NUM_CH-1:0] = status_mask;
        end else if (wb_adr == adc_trig_pkg::reg_count) begin
            rd_word = event_count;
        end
        for (int i = 0; i < NUM_CH; i++) begin
            if (lvl_sel[i]) begin
                rd_word.lvl.level = level_q[i];
            end
        end
    end

    // Flatten levels for the channel slices
    for (genvar i = 0; i < NUM_CH; i++) begin : g_level
        assign level[i*adc_trig_pkg::level_w +: adc_trig_pkg::level_w] = level_q[i];
    end

endmodule

// ==== rtl/trig_combiner.sv ====
module trig_combiner #(
    parameter int NUM_CH = 4
) (
    input  logic                                 adc_clk,
    input  logic                                 rst_n,
    // One bit per channel slice
    input  logic [NUM_CH-1:0]                    chan_trig,
    input  logic [NUM_CH-1:0]                    enable_mask,
    // 0 selects OR, 1 selects AND
    input  logic                                 and_mode,
    // One cycle pulse from the control register
    input  logic                                 clear,
    output logic                                 trigger_out,
    output logic [NUM_CH-1:0]                    status_mask,
    output logic [adc_trig_pkg::wb_data_w-1:0]   event_count
);

    //////////////////////////////
    // Combine
    //////////////////////////////

    logic [NUM_CH-1:0] masked;
    logic              any_hit;
    logic              all_hit;
    logic              fire;
    logic              rise;

    // Disabled channels drop out
    assign masked = chan_trig & enable_mask;

    // OR mode, any enabled channel
    assign any_hit = |masked;

    // AND mode, every enabled channel and at least one enabled
    assign all_hit = (masked == enable_mask) && (|enable_mask);

    assign fire = and_mode ? all_hit : any_hit;

    // Output about to go from 0 to 1
    assign rise = fire && !trigger_out;

    // Registered trigger
    always_ff @(posedge adc_clk) begin
        if (!rst_n) begin
            trigger_out <= 1'b0;
        end else begin
            trigger_out <= fire;
        end
    end

    //////////////////////////////
    // Status and count
    //////////////////////////////

    // Both cleared together, clear wins over a new event
    always_ff @(posedge adc_clk) begin
        if (!rst_n) begin
            status_mask <= '0;
            event_count <= '0;
        end else if (clear) begin
            status_mask <= '0;
            event_count <= '0;
        end else if (rise) begin
            event_count <= event_count + 1'b1;
            // Only the first event after a clear is recorded
            if (status_mask == '0) begin
                status_mask <= masked;
            end
        end
    end

endmodule

// ==== rtl/trig_channel.sv ====
module trig_channel #(
    parameter int SAMPLE_W = 16
) (
    input  logic                        adc_clk,
    input  logic                        rst_n,
    // Two's complement samples from the frontend
    input  logic [SAMPLE_W-1:0]         sample_first,
    input  logic [SAMPLE_W-1:0]         sample_second,
    input  logic                        sample_valid,
    // Threshold in pair sum units
    input  logic signed [adc_trig_pkg::level_width(SAMPLE_W)-1:0] level,
    // 1 fires below the level, 0 above it
    input  logic                        below,
    output logic                        chan_trig
);

    // Sum width, two guard bits over one sample
    localparam int SUM_W = adc_trig_pkg::level_width(SAMPLE_W);

    //////////////////////////////
    // Pair sum
    //////////////////////////////

    logic signed [SUM_W-1:0] first_ext;
    logic signed [SUM_W-1:0] second_ext;
    logic signed [SUM_W-1:0] pair_sum;

    // Sign extension by two bits
    assign first_ext = {{2{sample_first[SAMPLE_W-1]}}, sample_first};
    assign second_ext = {{2{sample_second[SAMPLE_W-1]}}, sample_second};

    // Twice the pair mean, held between strobes
    always_ff @(posedge adc_clk) begin
        if (!rst_n) begin
            pair_sum <= '0;
        end else if (sample_valid) begin
            pair_sum <= first_ext + second_ext;
        end
    end

    //////////////////////////////
    // Level compare
    //////////////////////////////

    // Evaluated every cycle so a new level acts at once
    always_ff @(posedge adc_clk) begin
        if (!rst_n) begin
            chan_trig <= 1'b0;
        end else if (below) begin
            // Strictly less, equal does not fire
            chan_trig <= (pair_sum < level);
        end else begin
            // Strictly greater
            chan_trig <= (pair_sum > level);
        end
    end

endmodule

// ==== rtl/adc_frontend.sv ====
module adc_frontend #(
    parameter int NUM_CH = 4,
    parameter int SAMPLE_W = 16
) (
    input  logic                       adc_clk,
    input  logic                       rst_n,
    // Flat word bus, channel 0 in the lowest bits
    input  logic [NUM_CH*2*SAMPLE_W-1:0] adc_data,
    input  logic [NUM_CH-1:0]          adc_valid,
    // Split samples, channel 0 in the lowest bits
    output logic [NUM_CH*SAMPLE_W-1:0] sample_first,
    output logic [NUM_CH*SAMPLE_W-1:0] sample_second,
    output logic [NUM_CH-1:0]          sample_valid
);

    // One ADC word carries two samples
    localparam int WORD_W = 2 * SAMPLE_W;

    //////////////////////////////
    // Sample capture
    //////////////////////////////

    // Payload registers, loaded only on their own strobe
    always_ff @(posedge adc_clk) begin
        for (int ch = 0; ch < NUM_CH; ch++) begin
            // Each channel keeps its samples until its next strobe
            if (adc_valid[ch]) begin
                // First sample sits in the low half of the word
                sample_first[ch*SAMPLE_W +: SAMPLE_W] <=
                    adc_data[ch*WORD_W +: SAMPLE_W];
                // Second sample in the high half
                sample_second[ch*SAMPLE_W +: SAMPLE_W] <=
                    adc_data[ch*WORD_W + SAMPLE_W +: SAMPLE_W];
            end
        end
    end

    //////////////////////////////
    // Strobe delay
    //////////////////////////////

    // Strobe follows the data by one cycle, lasts one cycle
    always_ff @(posedge adc_clk) begin
        if (!rst_n) begin
            sample_valid <= '0;
        end else begin
            sample_valid <= adc_valid;
        end
    end

endmodule

// ==== rtl/adc_trig_pkg.sv ====
package adc_trig_pkg;

    //////////////////////////////
    // Channel and bus sizing
    //////////////////////////////

    // Most channels the control word can address
    localparam int unsigned max_ch = 8;

    // Wishbone word address and data widths
    localparam int unsigned wb_adr_w = 4;
    localparam int unsigned wb_data_w = 32;

    //////////////////////////////
    // Register map
    //////////////////////////////

    // Control word with clear, mode, polarity and enable
    localparam logic [wb_adr_w-1:0] reg_ctrl = 4'd0;
    // First level register, one word per channel follows
    localparam logic [wb_adr_w-1:0] reg_level_base = 4'd1;
    // Sticky mask of the channels behind the first trigger
    localparam logic [wb_adr_w-1:0] reg_status = 4'd12;
    // Trigger event count
    localparam logic [wb_adr_w-1:0] reg_count = 4'd13;

    //////////////////////////////
    // Level width rule
    //////////////////////////////

    // Pair sum needs two guard bits over one sample
    function automatic int unsigned level_width(int unsigned sample_w);
        return sample_w + 2;
    endfunction

    // Level field held in the register word
    localparam int unsigned level_w = level_width(16);

    // Unused upper bits of each register view
    localparam int unsigned level_pad_w = wb_data_w - level_w;
    localparam int unsigned ctrl_pad_w = wb_data_w - 2 - 2 * max_ch;

    //////////////////////////////
    // Register word views
    //////////////////////////////

    // Level register, signed level in the low bits
    typedef struct packed {
        logic [level_pad_w-1:0]   pad;
        logic signed [level_w-1:0] level;
    } level_view_t;

    // Control register, clear in the top bit
    typedef struct packed {
        logic                    clear;
        logic [ctrl_pad_w-1:0]   pad;
        // 0 selects OR, 1 selects AND
        logic                    and_mode;
        // 1 fires below the level
        logic [max_ch-1:0]       below;
        logic [max_ch-1:0]       enable;
    } ctrl_view_t;

    // One bus word seen as a level or as the control word
    typedef union packed {
        level_view_t lvl;
        ctrl_view_t  ctrl;
    } reg_word_u;

endpackage
